/* sim.f */
hdl/cache_biu_pkg.sv
hdl/line_buf_if.sv
hdl/biu_burst_seq.sv
hdl/biu_line_buf.sv
hdl/biu_resp_tracker.sv
hdl/cache_biu_top.sv
bench/tb_clock_gen.sv
bench/tb_cache_biu.sv

/* Makefile */
# Verilator build and run of the cache bus controller testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator from sim.f and run the testbench"
	@echo "  clean  remove the build folder"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_cache_biu -Mdir build
	@out="$$(./build/Vtb_cache_biu)"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf build

/* bench/tb_cache_biu.sv */
//////////////////////////////
// cache bus controller testbench
// BIU responder and directed tests
//////////////////////////////

`timescale 1ns/100ps

module tb_cache_biu;

  logic clk_i, rst_ni, flush_i, nc_req_i, we_i;
  logic biu_stb_ack_i, biu_d_ack_i, biu_ack_i, biu_err_i;
  logic biucmd_ack_o, biucmd_busy_o, nc_ack_o, biu_stb_o, biu_we_o;
  logic [cache_biu_pkg::PLEN-1:0] adr_i, evict_adr_i, biu_adro_i, biu_adri_o;
  logic [cache_biu_pkg::INFLIGHT_BITS-1:0] inflight_cnt_o;
  cache_biu_pkg::biucmd_t   biucmd_i;
  cache_biu_pkg::biu_type_t biu_type_o;
  cache_biu_pkg::word_t     d_i, biu_q_i, biu_d_o;
  cache_biu_pkg::line_t     evict_line_i, line_o;
  int          err_cnt       = 0;
  int          check_cnt     = 0;
  int          errs_at_start = 0;               // error count when a test began
  logic [31:0] lcg_state     = 32'hb461_3372;   // write-back data source

  tb_clock_gen i_clock_gen (.clk_o (clk_i), .rst_no (rst_ni));

  cache_biu_top i_cache_biu_top (.*);

  //////////////////////////////
  // helpers
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // BIU read data for a word address
  function automatic cache_biu_pkg::word_t mem_word(input logic [31:0] a);
    return {a[15:0], ~a[15:0]} ^ 32'h0f1e_2d3c;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic check_eq(input string name, input logic [127:0] act, input logic [127:0] exp);
    check_cnt++;
    assert (act === exp)
    else
    begin
      $display("error at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // wait loop ran out before its condition came true
  task automatic check_true(input logic cond, input string why);
    check_cnt++;
    assert (cond === 1'b1)
    else
    begin
      $display("%s", why);
      err_cnt++;
    end
  endtask

  task automatic drive_slot();
    @(posedge clk_i);
    #2;   // inputs change just after the edge
  endtask

  task automatic report(input string name);
    $display("test %s: %s", name, (err_cnt == errs_at_start) ? "ok" : "had errors");
  endtask

  //////////////////////////////
  // line command as seen by the BIU
  // stall is the number of cycles the strobe is held off
  task automatic run_line(input logic wr, input logic [31:0] addr,
                          input cache_biu_pkg::line_t wline, input int stall);
    logic [31:0] exp_adr, base, d_first;
    cache_biu_pkg::line_t exp_line;
    int i;
    int beats;
    exp_adr = wr ? addr : {addr[31:2], 2'b00};
    base    = {addr[31:4], 4'h0};
    for (i = 0; i < 4; i++)
      exp_line[i*32 +: 32] = wr ? wline[i*32 +: 32] : mem_word(base + 4 * i);
    for (i = 0; i <= stall; i++)
    begin
      drive_slot();
      if (i > 0)
        biucmd_i = cache_biu_pkg::BIUCMD_NOP;   // one cycle of command is enough
      else if (wr)
        biucmd_i = cache_biu_pkg::BIUCMD_WRITEWAY;
      else
        biucmd_i = cache_biu_pkg::BIUCMD_READWAY;
      adr_i         = addr;
      evict_adr_i   = addr;
      evict_line_i  = wline;
      biu_stb_ack_i = (i == stall);
      @(negedge clk_i);
      if (i == 0)
        d_first = biu_d_o;
      check_eq("biu_stb_o", biu_stb_o, 1'b1);
      check_eq("biu_adri_o", biu_adri_o, exp_adr);
      check_eq("biu_we_o", biu_we_o, wr);
      check_eq("biu_type_o", biu_type_o, cache_biu_pkg::WRAP4);
      if (wr || i > 0)
        check_eq("biu_d_o", biu_d_o, wr ? wline[31:0] : d_first);   // word 0 rides the strobe
    end
    drive_slot();
    biucmd_i      = cache_biu_pkg::BIUCMD_NOP;
    biu_stb_ack_i = 1'b0;
    @(negedge clk_i);
    check_eq("biu_stb_o", biu_stb_o, 1'b0);
    check_eq("biucmd_busy_o", biucmd_busy_o, 1'b1);
    check_eq("inflight_cnt_o", inflight_cnt_o, 3'd4);   // whole burst outstanding
    // offer beats until the command is acknowledged
    beats = 0;
    while (!biucmd_ack_o && beats < 8)
    begin
      drive_slot();
      biu_ack_i   = 1'b1;
      biu_adro_i  = base + 4 * ((addr[3:2] + beats) % 4);   // wrap from critical word
      biu_q_i     = mem_word(biu_adro_i);
      biu_d_ack_i = wr && beats < 3;
      @(negedge clk_i);
      if (wr && beats < 3)
        check_eq("biu_d_o", biu_d_o, wline[(beats+1)*32 +: 32]);
      beats++;
    end
    check_true(biucmd_ack_o, "line command was never acknowledged");
    check_eq("beats", beats, 4);
    if (!wr)
      check_eq("line_o", line_o, exp_line);   // line order despite wrap order
    drive_slot();
    biu_ack_i   = 1'b0;
    biu_d_ack_i = 1'b0;
    @(negedge clk_i);
    check_eq("biucmd_busy_o", biucmd_busy_o, 1'b0);
    check_eq("inflight_cnt_o", inflight_cnt_o, 3'd0);
  endtask

  //////////////////////////////
  // single non-cacheable read flushed while outstanding if asked
  task automatic run_single(input logic [31:0] addr, input logic flush);
    drive_slot();
    nc_req_i      = 1'b1;
    adr_i         = addr;
    we_i          = 1'b0;
    biu_stb_ack_i = 1'b1;
    @(negedge clk_i);
    check_eq("biu_stb_o", biu_stb_o, 1'b1);
    check_eq("biu_type_o", biu_type_o, cache_biu_pkg::INCR);
    check_eq("biu_adri_o", biu_adri_o, addr);
    drive_slot();
    nc_req_i      = 1'b0;
    biu_stb_ack_i = 1'b0;
    flush_i       = flush;
    @(negedge clk_i);
    check_eq("biu_stb_o", biu_stb_o, 1'b0);   // strobe follows nc_req
    check_eq("inflight_cnt_o", inflight_cnt_o, 3'd1);
    drive_slot();
    flush_i   = 1'b0;
    biu_ack_i = 1'b1;
    biu_q_i   = mem_word(addr);
    @(negedge clk_i);
    check_eq("nc_ack_o", nc_ack_o, !flush);   // stale ack dropped
    drive_slot();
    biu_ack_i = 1'b0;
    @(negedge clk_i);
    check_eq("inflight_cnt_o", inflight_cnt_o, 3'd0);
  endtask

  //////////////////////////////
  // directed tests
  initial
  begin
    int n;
    cache_biu_pkg::line_t wl;
    flush_i       = 1'b0;
    biucmd_i      = cache_biu_pkg::BIUCMD_NOP;
    nc_req_i      = 1'b0;
    adr_i         = '0;
    we_i          = 1'b0;
    d_i           = '0;
    evict_adr_i   = '0;
    evict_line_i  = '0;
    biu_stb_ack_i = 1'b0;
    biu_d_ack_i   = 1'b0;
    biu_adro_i    = '0;
    biu_q_i       = '0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    n = 0;
    while (!rst_ni && n < 20)
    begin
      @(posedge clk_i);
      n++;
    end
    check_true(rst_ni, "reset was never released");
    @(negedge clk_i);
    check_eq("biucmd_busy_o", biucmd_busy_o, 1'b0);
    check_eq("biucmd_ack_o", biucmd_ack_o, 1'b0);
    check_eq("nc_ack_o", nc_ack_o, 1'b0);
    check_eq("biu_stb_o", biu_stb_o, 1'b0);
    check_eq("inflight_cnt_o", inflight_cnt_o, 3'd0);
    report("reset");
    errs_at_start = err_cnt;
    run_line(1'b0, 32'h1000_0049, '0, 0);   // critical word 2 at an odd byte
    report("line fill");
    errs_at_start = err_cnt;
    for (n = 0; n < 4; n++)
    begin
      lcg_state        = lcg_next(lcg_state);
      wl[n*32 +: 32]   = lcg_state;
    end
    run_line(1'b1, 32'h2000_0040, wl, 0);
    report("write-back");
    errs_at_start = err_cnt;
    run_line(1'b0, 32'h1000_0084, '0, 3);
    report("back-pressure");
    errs_at_start = err_cnt;
    run_single(32'h3000_0010, 1'b0);
    run_line(1'b0, 32'h1000_00cc, '0, 0);   // inflight 4 before first beat
    report("non-cacheable");
    errs_at_start = err_cnt;
    run_single(32'h3000_0020, 1'b1);
    run_single(32'h3000_0024, 1'b0);
    report("flush");
    $display("tests 6, checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // overall run limit
  initial
  begin
    #100000;
    abort_run("simulation time limit reached");
  end

endmodule

/* bench/tb_clock_gen.sv */
//////////////////////////////
// testbench clock and reset
// 20 ns clock, reset low for 4 cycles
//////////////////////////////

`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial
  begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    #2 rst_no = 1'b1;   // release away from the edge
  end

  always #10 clk_o = ~clk_o;   // 20 ns period

endmodule

/* hdl/cache_biu_top.sv */
//////////////////////////////
// data cache bus controller
// line fill, write-back and non-cacheable
// transfers towards a burst BIU
//////////////////////////////

`timescale 1ns/100ps

module cache_biu_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    flush_i,
  // cache side
  input  cache_biu_pkg::biucmd_t                  biucmd_i,
  output logic                                    biucmd_ack_o,
  output logic                                    biucmd_busy_o,
  input  logic                                    nc_req_i,
  output logic                                    nc_ack_o,
  output logic [cache_biu_pkg::INFLIGHT_BITS-1:0] inflight_cnt_o,
  input  logic [cache_biu_pkg::PLEN-1:0]          adr_i,
  input  logic                                    we_i,
  input  cache_biu_pkg::word_t                    d_i,
  input  logic [cache_biu_pkg::PLEN-1:0]          evict_adr_i,
  input  cache_biu_pkg::line_t                    evict_line_i,
  output cache_biu_pkg::line_t                    line_o,      // filled line
  // BIU side
  output logic                                    biu_stb_o,
  input  logic                                    biu_stb_ack_i,
  input  logic                                    biu_d_ack_i,
  output logic [cache_biu_pkg::PLEN-1:0]          biu_adri_o,
  input  logic [cache_biu_pkg::PLEN-1:0]          biu_adro_i,
  output cache_biu_pkg::biu_type_t                biu_type_o,
  output logic                                    biu_we_o,
  output cache_biu_pkg::word_t                    biu_d_o,
  input  cache_biu_pkg::word_t                    biu_q_i,
  input  logic                                    biu_ack_i,
  input  logic                                    biu_err_i
);

  logic strobe_burst;   // current strobe is a line burst

  line_buf_if i_lb_if ();

  assign line_o = i_lb_if.line;

  //////////////////////////////
  // sequencer
  biu_burst_seq i_burst_seq (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .biucmd_i       (biucmd_i),
    .nc_req_i       (nc_req_i),
    .adr_i          (adr_i),
    .we_i           (we_i),
    .d_i            (d_i),
    .evict_adr_i    (evict_adr_i),
    .evict_line_i   (evict_line_i),
    .biu_stb_ack_i  (biu_stb_ack_i),
    .biu_d_ack_i    (biu_d_ack_i),
    .biu_adro_i     (biu_adro_i),
    .biu_q_i        (biu_q_i),
    .biu_ack_i      (biu_ack_i),
    .biu_err_i      (biu_err_i),
    .biucmd_ack_o   (biucmd_ack_o),
    .biucmd_busy_o  (biucmd_busy_o),
    .biu_stb_o      (biu_stb_o),
    .biu_adri_o     (biu_adri_o),
    .biu_type_o     (biu_type_o),
    .biu_we_o       (biu_we_o),
    .biu_d_o        (biu_d_o),
    .strobe_burst_o (strobe_burst),
    .lb             (i_lb_if.seq_mp)
  );

  biu_line_buf i_line_buf (
    .clk_i (clk_i),
    .lb    (i_lb_if.buf_mp)
  );

  // in-flight and flush bookkeeping
  biu_resp_tracker i_resp_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .strobe_burst_i (strobe_burst),
    .biu_stb_ack_i  (biu_stb_ack_i),
    .biu_ack_i      (biu_ack_i),
    .biu_err_i      (biu_err_i),
    .inflight_cnt_o (inflight_cnt_o),
    .nc_ack_o       (nc_ack_o)
  );

endmodule

/* hdl/biu_resp_tracker.sv */
//////////////////////////////
// response tracker
// counts transfers in flight, discards
// stale acknowledges after a flush
//////////////////////////////

`timescale 1ns/100ps

module biu_resp_tracker (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    flush_i,
  input  logic                                    strobe_burst_i,
  input  logic                                    biu_stb_ack_i,
  input  logic                                    biu_ack_i,
  input  logic                                    biu_err_i,
  output logic [cache_biu_pkg::INFLIGHT_BITS-1:0] inflight_cnt_o,
  output logic                                    nc_ack_o
);

  logic [cache_biu_pkg::INFLIGHT_BITS-1:0] discard_q;   // acks still to drop
  logic [cache_biu_pkg::INFLIGHT_BITS-1:0] issued;
  logic beat_end;

  assign beat_end = biu_ack_i | biu_err_i;

  // transfers added by an accepted strobe
  assign issued = !biu_stb_ack_i  ? '0 :
                  strobe_burst_i  ? cache_biu_pkg::INFLIGHT_BITS'(cache_biu_pkg::BURST_SIZE) :
                                    cache_biu_pkg::INFLIGHT_BITS'(1);

  //////////////////////////////
  // in-flight count
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inflight_cnt_o <= '0;
    else
      inflight_cnt_o <= inflight_cnt_o + issued - {{(cache_biu_pkg::INFLIGHT_BITS-1){1'b0}},
                                                   beat_end};
  end

  //////////////////////////////
  // flush discard
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      discard_q <= '0;
    else if (flush_i)
    begin
      if (|inflight_cnt_o && beat_end)
        discard_q <= inflight_cnt_o - 1'b1;   // this beat is already gone
      else
        discard_q <= inflight_cnt_o;
    end
    else if (|discard_q && beat_end)
      discard_q <= discard_q - 1'b1;
  end

  // only fresh acks reach the cache
  assign nc_ack_o = biu_ack_i & ~flush_i & ~|discard_q;

endmodule

/* hdl/biu_line_buf.sv */
//////////////////////////////
// line buffer
// assembles filled words by index, shifts
// the evicted line out for write-back
//////////////////////////////

`timescale 1ns/100ps

module biu_line_buf (
  input  logic        clk_i,
  line_buf_if.buf_mp  lb
);

  cache_biu_pkg::line_t buf_q;

  //////////////////////////////
  // line register
  always_ff @(posedge clk_i)
  begin
    if (lb.evict_load)
    begin
      // word 0 leaves with the strobe, keep words 1..3
      buf_q <= lb.evict_line >> cache_biu_pkg::XLEN;
    end
    else if (lb.fill_we)
    begin
      // beats may come back in wrap order
      buf_q[lb.fill_idx*cache_biu_pkg::XLEN +: cache_biu_pkg::XLEN] <= lb.fill_word;
    end
    else if (lb.shift)
    begin
      buf_q <= buf_q >> cache_biu_pkg::XLEN;   // next write-back word to head
    end
  end

  // head of buffer feeds biu_d_o in BURST
  assign lb.head_word = buf_q[cache_biu_pkg::XLEN-1:0];

  //////////////////////////////
  // assembled line
  // last beat is not yet registered when the
  // command is acknowledged, so overlay it
  always_comb
  begin
    lb.line = buf_q;
    lb.line[lb.fill_idx*cache_biu_pkg::XLEN +: cache_biu_pkg::XLEN] = lb.fill_word;
  end

endmodule

/* hdl/biu_burst_seq.sv */
//////////////////////////////
// burst sequencer
// issues line and single strobes to the BIU,
// stretches them under back-pressure, counts
// beats and drives the line buffer
//////////////////////////////

`timescale 1ns/100ps

module biu_burst_seq (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  cache_biu_pkg::biucmd_t           biucmd_i,
  input  logic                             nc_req_i,
  input  logic [cache_biu_pkg::PLEN-1:0]   adr_i,
  input  logic                             we_i,
  input  cache_biu_pkg::word_t             d_i,
  input  logic [cache_biu_pkg::PLEN-1:0]   evict_adr_i,
  input  cache_biu_pkg::line_t             evict_line_i,
  input  logic                             biu_stb_ack_i,
  input  logic                             biu_d_ack_i,
  input  logic [cache_biu_pkg::PLEN-1:0]   biu_adro_i,
  input  cache_biu_pkg::word_t             biu_q_i,
  input  logic                             biu_ack_i,
  input  logic                             biu_err_i,
  output logic                             biucmd_ack_o,
  output logic                             biucmd_busy_o,
  output logic                             biu_stb_o,
  output logic [cache_biu_pkg::PLEN-1:0]   biu_adri_o,
  output cache_biu_pkg::biu_type_t         biu_type_o,
  output logic                             biu_we_o,
  output cache_biu_pkg::word_t             biu_d_o,
  output logic                             strobe_burst_o,
  line_buf_if.seq_mp                       lb
);

  cache_biu_pkg::seq_state_t state_q;
  logic [cache_biu_pkg::BURST_BITS-1:0] beat_cnt;
  logic [cache_biu_pkg::PLEN-1:0] adri_hold;   // strobe fields kept for WAIT4BIU
  logic                           we_hold;
  cache_biu_pkg::word_t           d_hold;
  logic in_idle, in_wait, in_burst;
  logic line_cmd;

  assign in_idle  = (state_q == cache_biu_pkg::IDLE);
  assign in_wait  = (state_q == cache_biu_pkg::WAIT4BIU);
  assign in_burst = (state_q == cache_biu_pkg::BURST);
  assign line_cmd = (biucmd_i != cache_biu_pkg::BIUCMD_NOP);

  // last beat or bus error ends the line command
  assign biucmd_ack_o = in_burst & (biu_err_i | (~|beat_cnt & biu_ack_i));

  //////////////////////////////
  // FSM
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q       <= cache_biu_pkg::IDLE;
      biucmd_busy_o <= 1'b0;
    end
    else
    begin
      case (state_q)
        cache_biu_pkg::IDLE:
        begin
          if (line_cmd)
          begin
            biucmd_busy_o <= 1'b1;
            // BIU may not take the strobe right away
            state_q <= biu_stb_ack_i ? cache_biu_pkg::BURST : cache_biu_pkg::WAIT4BIU;
          end
        end
        cache_biu_pkg::WAIT4BIU:
        begin
          if (biu_stb_ack_i)
            state_q <= cache_biu_pkg::BURST;
        end
        cache_biu_pkg::BURST:
        begin
          if (biucmd_ack_o)
          begin
            state_q       <= cache_biu_pkg::IDLE;
            biucmd_busy_o <= 1'b0;
          end
        end
        default: state_q <= cache_biu_pkg::IDLE;
      endcase
    end
  end

  // beats left, counts down from 3
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      beat_cnt <= '1;
    else if (in_idle)
      beat_cnt <= '1;
    else if (in_burst && biu_ack_i)
      beat_cnt <= beat_cnt - 1'b1;
  end

  //////////////////////////////
  // strobe fields
  always_comb
  begin
    biu_stb_o  = 1'b0;
    biu_adri_o = adri_hold;
    biu_we_o   = we_hold;
    biu_d_o    = d_hold;
    case (state_q)
      cache_biu_pkg::IDLE:
      begin
        case (biucmd_i)
          cache_biu_pkg::BIUCMD_READWAY:
          begin
            biu_stb_o  = 1'b1;
            biu_adri_o = {adr_i[cache_biu_pkg::PLEN-1:cache_biu_pkg::BURST_LSB],
                          {cache_biu_pkg::BURST_LSB{1'b0}}};   // word aligned
            biu_we_o   = 1'b0;
            biu_d_o    = '0;
          end
          cache_biu_pkg::BIUCMD_WRITEWAY:
          begin
            biu_stb_o  = 1'b1;
            biu_adri_o = evict_adr_i;
            biu_we_o   = 1'b1;
            biu_d_o    = evict_line_i[cache_biu_pkg::XLEN-1:0];  // word 0 goes with strobe
          end
          default:
          begin
            biu_stb_o  = nc_req_i;   // non-cacheable single
            biu_adri_o = adr_i;
            biu_we_o   = we_i;
            biu_d_o    = d_i;
          end
        endcase
      end
      cache_biu_pkg::WAIT4BIU: biu_stb_o = 1'b1;      // hold fields until accepted
      cache_biu_pkg::BURST:    biu_d_o   = lb.head_word;
      default: ;
    endcase
  end

  assign biu_type_o = (in_idle && !line_cmd) ? cache_biu_pkg::INCR : cache_biu_pkg::WRAP4;

  // strobe is a line burst, for the tracker
  assign strobe_burst_o = (in_idle & line_cmd) | in_wait;

  // capture what was driven while idle
  always_ff @(posedge clk_i)
  begin
    if (in_idle)
    begin
      adri_hold <= biu_adri_o;
      we_hold   <= biu_we_o;
      d_hold    <= biu_d_o;
    end
  end

  //////////////////////////////
  // line buffer control
  assign lb.evict_load = in_idle & (biucmd_i == cache_biu_pkg::BIUCMD_WRITEWAY);
  assign lb.evict_line = evict_line_i;
  assign lb.fill_we    = in_burst & ~we_hold & biu_ack_i;
  assign lb.fill_idx   = biu_adro_i[cache_biu_pkg::BURST_LSB +: cache_biu_pkg::BURST_BITS];
  assign lb.fill_word  = biu_q_i;
  assign lb.shift      = in_burst & we_hold & biu_d_ack_i;   // BIU wants next word

endmodule

/* hdl/line_buf_if.sv */
//////////////////////////////
// line buffer link
// sequencer to line buffer pulses and the
// buffer's head word and assembled line
//////////////////////////////

`timescale 1ns/100ps

interface line_buf_if;

  logic                      evict_load;  // load evicted line, shifted by one word
  cache_biu_pkg::line_t      evict_line;
  logic                      fill_we;     // write one returned read word
  logic [cache_biu_pkg::BURST_BITS-1:0] fill_idx;
  cache_biu_pkg::word_t      fill_word;
  logic                      shift;       // next write-back word
  cache_biu_pkg::word_t      head_word;   // word 0 of the buffer
  cache_biu_pkg::line_t      line;        // buffer with current beat overlaid

  // sequencer side drives all pulses
  modport seq_mp (
    output evict_load, evict_line, fill_we, fill_idx, fill_word, shift,
    input  head_word
  );

  // buffer side
  modport buf_mp (
    input  evict_load, evict_line, fill_we, fill_idx, fill_word, shift,
    output head_word, line
  );

endinterface

/* hdl/cache_biu_pkg.sv */
//////////////////////////////
// cache bus controller package
// bus widths, line geometry, command and
// burst encodings, sequencer states
//////////////////////////////

package cache_biu_pkg;

  //////////////////////////////
  // bus and line geometry
  localparam int XLEN          = 32;           // data bus width
  localparam int PLEN          = 32;           // physical address width
  localparam int BURST_SIZE    = 4;            // words per line
  localparam int BURST_BITS    = 2;            // word index within a line
  localparam int BURST_LSB     = 2;            // byte offset bits in a word
  localparam int LINE_BITS     = XLEN * BURST_SIZE;
  localparam int INFLIGHT_BITS = 3;            // one burst plus one single

  //////////////////////////////
  // payload types
  typedef logic [LINE_BITS-1:0] line_t;
  typedef logic [XLEN-1:0]      word_t;

  // command from the miss handler
  typedef enum logic [1:0] {
    BIUCMD_NOP,
    BIUCMD_READWAY,
    BIUCMD_WRITEWAY
  } biucmd_t;

  // burst type on the bus, AHB style ordering
  typedef enum logic [2:0] {
    SINGLE,
    INCR,
    WRAP4,
    INCR4,
    WRAP8,
    INCR8,
    WRAP16,
    INCR16
  } biu_type_t;

  // burst sequencer FSM
  typedef enum logic [1:0] {
    IDLE,
    WAIT4BIU,   // strobe stretched, waiting for acceptance
    BURST       // beats in progress
  } seq_state_t;

endpackage
